// File: alu_req_if.sv
interface alu_req_if import simd_alu_pkg::*; ();

  // Operands and control, held by the register block
  elen_t   opa;
  elen_t   opb;
  alu_op_e op;
  vew_e    vew;

  // One cycle per request
  logic    start;

  modport regs_mp (
    output opa,
    output opb,
    output op,
    output vew,
    output start
  );

  modport core_mp (
    input opa,
    input opb,
    input op,
    input vew,
    input start
  );

endinterface

// File: alu_wb_top.f
simd_alu_pkg.sv
alu_req_if.sv
wb_alu_regs.sv
simd_lane_compare.sv
simd_alu_core.sv
alu_wb_top.sv
tb_alu_wb_top.sv

// File: alu_wb_top.sv
module alu_wb_top import simd_alu_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     wb_cyc_i,
  input  logic     wb_stb_i,
  input  logic     wb_we_i,
  input  wb_addr_t wb_adr_i,
  input  wb_data_t wb_dat_i,
  output wb_data_t wb_dat_o,
  output logic     wb_ack_o
);

  elen_t result;
  strb_t vxsat;
  logic  done;

  alu_req_if req_if ();

  wb_alu_regs u_regs (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .result_i (result),
    .vxsat_i  (vxsat),
    .done_i   (done),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .req      (req_if.regs_mp)
  );

  simd_alu_core u_core (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req      (req_if.core_mp),
    .result_o (result),
    .vxsat_o  (vxsat),
    .done_o   (done)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f alu_wb_top.f --top-module tb_alu_wb_top -o tb_alu_wb_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_alu_wb_top > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi
exit 0

// File: simd_alu_core.sv
module simd_alu_core import simd_alu_pkg::*; (
  input  logic  clk_i,
  input  logic  reset_i,
  alu_req_if.core_mp req,
  output elen_t result_o,
  output strb_t vxsat_o,
  output logic  done_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Lane functions
  ////////////////////////////////////////////////////////////////////////////

  // Signed clamp of a wide result, sat flag on top
  function automatic logic [ELEN:0] sat_clamp(input logic [ELEN+1:0] v,
                                              input logic [ELEN+1:0] smax,
                                              input logic [ELEN+1:0] smin);
    if ($signed(v) > $signed(smax)) return {1'b1, smax[ELEN-1:0]};
    if ($signed(v) < $signed(smin)) return {1'b1, smin[ELEN-1:0]};
    return {1'b0, v[ELEN-1:0]};
  endfunction

  // One element of lw bits, zero-extended in a and b; only the low lw bits are kept
  function automatic logic [ELEN:0] lane_alu(input alu_op_e     op,
                                             input elen_t       a,
                                             input elen_t       b,
                                             input int unsigned lw,
                                             input logic        lt,
                                             input logic        eq);
    logic [ELEN+1:0] msk;
    logic [ELEN+1:0] smax;
    logic [ELEN+1:0] smin;
    logic [ELEN+1:0] sa;
    logic [ELEN+1:0] sb;
    logic [ELEN+1:0] tmp;
    logic [5:0]      sh;
    logic            sat;
    elen_t           r;

    msk  = ((ELEN+2)'(1) << lw) - (ELEN+2)'(1);
    smax = msk >> 1;
    smin = ~smax;
    sa   = {2'b00, a} | (a[lw-1] ? ~msk : '0);
    sb   = {2'b00, b} | (b[lw-1] ? ~msk : '0);
    sh   = a[5:0] & 6'(lw - 1);
    sat  = 1'b0;
    r    = '0;
    tmp  = '0;

    case (op)
      OP_AND:  r = a & b;
      OP_OR:   r = a | b;
      OP_XOR:  r = a ^ b;
      OP_ADD:  r = b + a;
      OP_SUB:  r = b - a;
      OP_RSUB: r = a - b;
      OP_SADDU: begin
        tmp = {2'b00, a} + {2'b00, b};
        sat = tmp > msk;
        r   = sat ? msk[ELEN-1:0] : tmp[ELEN-1:0];
      end
      OP_SADD: begin
        tmp      = sb + sa;
        {sat, r} = sat_clamp(tmp, smax, smin);
      end
      OP_SSUBU: begin
        sat = a > b;
        r   = sat ? '0 : b - a;
      end
      OP_SSUB: begin
        tmp      = sb - sa;
        {sat, r} = sat_clamp(tmp, smax, smin);
      end
      OP_SLL: r = b << sh;
      OP_SRL: r = b >> sh;
      OP_SRA: begin
        tmp = $signed(sb) >>> sh;
        r   = tmp[ELEN-1:0];
      end
      OP_MINU, OP_MIN:     r = lt ? b : a;
      OP_MAXU, OP_MAX:     r = lt ? a : b;
      OP_MSEQ:             r[0] = eq;
      OP_MSNE:             r[0] = ~eq;
      OP_MSLT, OP_MSLTU:   r[0] = lt;
      OP_MSLE, OP_MSLEU:   r[0] = lt | eq;
      OP_MSGT, OP_MSGTU:   r[0] = ~(lt | eq);
      default: ;
    endcase
    return {sat, r};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  logic                   is_signed;
  strb_t                  less;
  strb_t                  equal;
  logic [3:0][ELEN-1:0]   res_w;
  logic [3:0][LANES8-1:0] sat_w;
  elen_t                  result_q;
  strb_t                  vxsat_q;
  logic                   done_q;

  assign is_signed = req.op inside {OP_MIN, OP_MAX, OP_MSLT, OP_MSLE, OP_MSGT};

  simd_lane_compare u_cmp (
    .opa_i       (req.opa),
    .opb_i       (req.opb),
    .vew_i       (req.vew),
    .is_signed_i (is_signed),
    .less_o      (less),
    .equal_o     (equal)
  );

  // Every width in parallel, picked by vew
  for (genvar w = 0; w < 4; w++) begin : g_width
    localparam int unsigned LW = 8 << w;
    localparam int unsigned NB = LW / 8;
    for (genvar l = 0; l < ELEN / LW; l++) begin : g_lane
      logic [ELEN:0] lane_out;
      assign lane_out = lane_alu(req.op, elen_t'(req.opa[l*LW +: LW]),
                                 elen_t'(req.opb[l*LW +: LW]), LW,
                                 less[l*NB], equal[l*NB]);
      assign res_w[w][l*LW +: LW] = lane_out[LW-1:0];
      assign sat_w[w][l*NB +: NB] = {NB{lane_out[ELEN]}};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_q <= '0;
      vxsat_q  <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= req.start;
      if (req.start) begin
        result_q <= res_w[req.vew];
        vxsat_q  <= sat_w[req.vew];
      end
    end
  end

  assign result_o = result_q;
  assign vxsat_o  = vxsat_q;
  assign done_o   = done_q;

endmodule

// File: simd_alu_pkg.sv
package simd_alu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and types
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned ELEN   = 64;
  localparam int unsigned LANES8 = ELEN / 8;
  localparam int unsigned WB_DW  = 32;
  localparam int unsigned WB_AW  = 5;

  typedef logic [ELEN-1:0]   elen_t;
  typedef logic [LANES8-1:0] strb_t;
  typedef logic [WB_DW-1:0]  wb_data_t;
  typedef logic [WB_AW-1:0]  wb_addr_t;
  typedef logic [2:0]        reg_idx_t;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Codes 25 to 31 are undefined
  typedef enum logic [4:0] {
    OP_AND   = 5'd0,
    OP_OR, OP_XOR,
    OP_ADD, OP_SUB, OP_RSUB,
    OP_SADDU, OP_SADD, OP_SSUBU, OP_SSUB,
    OP_SLL, OP_SRL, OP_SRA,
    OP_MINU, OP_MIN, OP_MAXU, OP_MAX,
    OP_MSEQ, OP_MSNE, OP_MSLT, OP_MSLTU, OP_MSLE, OP_MSLEU, OP_MSGT, OP_MSGTU
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Register map, word indices
  ////////////////////////////////////////////////////////////////////////////

  localparam reg_idx_t REG_OPA_LO = 3'd0;
  localparam reg_idx_t REG_OPA_HI = 3'd1;
  localparam reg_idx_t REG_OPB_LO = 3'd2;
  localparam reg_idx_t REG_OPB_HI = 3'd3;
  localparam reg_idx_t REG_CTRL   = 3'd4;
  localparam reg_idx_t REG_STATUS = 3'd5;
  localparam reg_idx_t REG_RES_LO = 3'd6;
  localparam reg_idx_t REG_RES_HI = 3'd7;

  // Control word fields
  localparam int unsigned CTRL_OP_LSB  = 0;
  localparam int unsigned CTRL_OP_MSB  = 4;
  localparam int unsigned CTRL_VEW_LSB = 8;
  localparam int unsigned CTRL_VEW_MSB = 9;

  // Status word fields
  localparam int unsigned STAT_DONE_BIT  = 0;
  localparam int unsigned STAT_VXSAT_LSB = 8;
  localparam int unsigned STAT_VXSAT_MSB = 15;

endpackage

// File: simd_lane_compare.sv
module simd_lane_compare import simd_alu_pkg::*; (
  input  elen_t opa_i,
  input  elen_t opb_i,
  input  vew_e  vew_i,
  input  logic  is_signed_i,
  output strb_t less_o,
  output strb_t equal_o
);

  // Extra top bit turns an unsigned compare into a signed one
  always_comb begin
    less_o  = '0;
    equal_o = '0;
    case (vew_i)
      EW8: for (int l = 0; l < 8; l++) begin
        less_o[l] = $signed({is_signed_i & opb_i[8*l+7], opb_i[8*l +: 8]}) <
                    $signed({is_signed_i & opa_i[8*l+7], opa_i[8*l +: 8]});
        equal_o[l] = opb_i[8*l +: 8] == opa_i[8*l +: 8];
      end
      EW16: for (int l = 0; l < 4; l++) begin
        less_o[2*l] = $signed({is_signed_i & opb_i[16*l+15], opb_i[16*l +: 16]}) <
                      $signed({is_signed_i & opa_i[16*l+15], opa_i[16*l +: 16]});
        equal_o[2*l] = opb_i[16*l +: 16] == opa_i[16*l +: 16];
      end
      EW32: for (int l = 0; l < 2; l++) begin
        less_o[4*l] = $signed({is_signed_i & opb_i[32*l+31], opb_i[32*l +: 32]}) <
                      $signed({is_signed_i & opa_i[32*l+31], opa_i[32*l +: 32]});
        equal_o[4*l] = opb_i[32*l +: 32] == opa_i[32*l +: 32];
      end
      EW64: begin
        less_o[0] = $signed({is_signed_i & opb_i[63], opb_i}) <
                    $signed({is_signed_i & opa_i[63], opa_i});
        equal_o[0] = opb_i == opa_i;
      end
      default: ;
    endcase
  end

endmodule

// File: tb_alu_wb_top.sv
module tb_alu_wb_top import simd_alu_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned SEED        = 46170;
  localparam int unsigned ACK_TIMEOUT = 20;
  localparam int unsigned POLL_LIMIT  = 20;
  localparam int unsigned RAND_ITERS  = 4;

  logic     clk_i;
  logic     reset_i;
  logic     wb_cyc_i;
  logic     wb_stb_i;
  logic     wb_we_i;
  wb_addr_t wb_adr_i;
  wb_data_t wb_dat_i;
  wb_data_t wb_dat_o;
  logic     wb_ack_o;

  wb_data_t rd;
  elen_t    opa;
  elen_t    opb;

  // Overflow pairs for the saturating ops at every width
  elen_t sat_a [6] = '{64'hFFFF_FFFF_FFFF_FFFF, 64'h7F7F_7F7F_7F7F_7F7F,
                       64'h8080_8080_8080_8080, 64'h7F7F_7F7F_7F7F_7F7F,
                       64'h8080_8080_8080_8080, 64'hFFFF_FFFF_FFFF_FFFF};
  elen_t sat_b [6] = '{64'hFFFF_FFFF_FFFF_FFFF, 64'h7F7F_7F7F_7F7F_7F7F,
                       64'h8080_8080_8080_8080, 64'h8080_8080_8080_8080,
                       64'h7F7F_7F7F_7F7F_7F7F, 64'h0000_0000_0000_0000};

  alu_wb_top u_dut (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Vxsat flags in the top byte and the result below
  function automatic logic [71:0] ref_alu(input alu_op_e op, input vew_e vew,
                                          input elen_t a, input elen_t b);
    int          w;
    logic [63:0] mask;
    logic [63:0] smax;
    logic [63:0] smin;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] r;
    logic [63:0] res;
    logic [64:0] sum;
    logic [7:0]  flags;
    logic [7:0]  bmask;
    logic [5:0]  sh;
    logic        sa;
    logic        sb;
    logic        sat;
    logic        ult;
    logic        slt;
    logic        eq;

    w     = 8 << vew;
    mask  = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
    smax  = mask >> 1;
    smin  = mask ^ smax;
    bmask = 8'((16'd1 << (w / 8)) - 16'd1);
    res   = '0;
    flags = '0;
    for (int e = 0; e < 64 / w; e++) begin
      ea  = (a >> (e * w)) & mask;
      eb  = (b >> (e * w)) & mask;
      sa  = ea[w-1];
      sb  = eb[w-1];
      sh  = ea[5:0] & 6'(w - 1);
      ult = eb < ea;
      slt = (sa != sb) ? sb : ult;
      eq  = eb == ea;
      sat = 1'b0;
      r   = '0;
      case (op)
        OP_AND:  r = ea & eb;
        OP_OR:   r = ea | eb;
        OP_XOR:  r = ea ^ eb;
        OP_ADD:  r = eb + ea;
        OP_SUB:  r = eb - ea;
        OP_RSUB: r = ea - eb;
        OP_SADDU: begin
          sum = {1'b0, eb} + {1'b0, ea};
          sat = sum > {1'b0, mask};
          r   = sat ? mask : sum[63:0];
        end
        OP_SSUBU: begin
          sat = ea > eb;
          r   = sat ? '0 : eb - ea;
        end
        OP_SADD, OP_SSUB: begin
          r = ((op == OP_SADD) ? eb + ea : eb - ea) & mask;
          if (((op == OP_SADD) == (sa == sb)) && (r[w-1] != sb)) begin
            sat = 1'b1;
            r   = sb ? smin : smax;
          end
        end
        OP_SLL: r = eb << sh;
        OP_SRL: r = eb >> sh;
        OP_SRA: begin
          r = eb >> sh;
          if (sb) r = r | (mask & ~(mask >> sh));
        end
        OP_MINU:  r = ult ? eb : ea;
        OP_MIN:   r = slt ? eb : ea;
        OP_MAXU:  r = ult ? ea : eb;
        OP_MAX:   r = slt ? ea : eb;
        OP_MSEQ:  r = {63'd0, eq};
        OP_MSNE:  r = {63'd0, ~eq};
        OP_MSLT:  r = {63'd0, slt};
        OP_MSLTU: r = {63'd0, ult};
        OP_MSLE:  r = {63'd0, slt | eq};
        OP_MSLEU: r = {63'd0, ult | eq};
        OP_MSGT:  r = {63'd0, ~(slt | eq)};
        OP_MSGTU: r = {63'd0, ~(ult | eq)};
        default:  r = '0;
      endcase
      res = res | ((r & mask) << (e * w));
      if (sat) flags = flags | (bmask << (e * w / 8));
    end
    return {flags, res};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks and bus access
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("Error: %s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %h actual %h", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic wait_ack();
    int unsigned cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!wb_ack_o) begin
      if (cycles == ACK_TIMEOUT) begin
        abort_run("no Wishbone ack within the timeout");
      end else begin
        cycles++;
        @(negedge clk_i);
      end
    end
  endtask

  // Drop the cycle and make sure ack does not repeat
  task automatic end_access();
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(negedge clk_i);
    check("single ack", 64'd0, 64'(wb_ack_o));
  endtask

  task automatic wb_write(input reg_idx_t idx, input wb_data_t data);
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = {idx, 2'b00};
    wb_dat_i = data;
    wait_ack();
    end_access();
  endtask

  task automatic wb_read(input reg_idx_t idx, output wb_data_t data);
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = {idx, 2'b00};
    wait_ack();
    data = wb_dat_o;
    end_access();
  endtask

  task automatic run_op(input string name, input alu_op_e op, input vew_e vew,
                        input elen_t a, input elen_t b);
    logic [71:0] exp;
    wb_data_t    ctrl;
    wb_data_t    st;
    wb_data_t    lo;
    wb_data_t    hi;
    int unsigned polls;

    ctrl = '0;
    ctrl[CTRL_OP_MSB:CTRL_OP_LSB]   = op;
    ctrl[CTRL_VEW_MSB:CTRL_VEW_LSB] = vew;
    wb_write(REG_OPA_LO, a[31:0]);
    wb_write(REG_OPA_HI, a[63:32]);
    wb_write(REG_OPB_LO, b[31:0]);
    wb_write(REG_OPB_HI, b[63:32]);
    wb_write(REG_CTRL, ctrl);
    polls = 0;
    st    = '0;
    while (!st[STAT_DONE_BIT]) begin
      if (polls == POLL_LIMIT) begin
        abort_run("status done bit never set");
      end else begin
        wb_read(REG_STATUS, st);
        polls++;
      end
    end
    wb_read(REG_RES_LO, lo);
    wb_read(REG_RES_HI, hi);
    exp = ref_alu(op, vew, a, b);
    check(name, exp[63:0], {hi, lo});
    check({name, " vxsat"}, 64'(exp[71:64]), 64'(st[STAT_VXSAT_MSB:STAT_VXSAT_LSB]));
  endtask

  function automatic elen_t rand64();
    return {$urandom, $urandom};
  endfunction

  // Copy the elements of a picked by sel into rnd
  function automatic elen_t mix_equal_lanes(input vew_e vew, input elen_t a,
                                            input elen_t rnd, input logic [7:0] sel);
    int    w;
    elen_t m;
    elen_t keep;
    w    = 8 << vew;
    m    = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
    keep = '0;
    for (int e = 0; e < 64 / w; e++) begin
      if (sel[e]) keep = keep | (m << (e * w));
    end
    return (a & keep) | (rnd & ~keep);
  endfunction

  function automatic string op_tag(input alu_op_e op, input vew_e vew);
    return $sformatf("%s/%0d", op.name(), 8 << vew);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_i    = 1'b0;
    reset_i  = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    void'($urandom(SEED));
    repeat (3) @(negedge clk_i);
    reset_i = 1'b0;

    wb_read(REG_STATUS, rd);
    check("reset status", 64'd0, 64'(rd));
    wb_read(REG_RES_LO, rd);
    check("reset result lo", 64'd0, 64'(rd));
    wb_read(REG_RES_HI, rd);
    check("reset result hi", 64'd0, 64'(rd));

    // Ctrl keeps only its two fields on read-back
    opa = rand64();
    opb = rand64();
    wb_write(REG_OPA_LO, opa[31:0]);
    wb_write(REG_OPA_HI, opa[63:32]);
    wb_write(REG_OPB_LO, opb[31:0]);
    wb_write(REG_OPB_HI, opb[63:32]);
    wb_write(REG_CTRL, 32'hFFFF_FF17);
    wb_read(REG_OPA_LO, rd);
    check("opa lo", 64'(opa[31:0]), 64'(rd));
    wb_read(REG_OPA_HI, rd);
    check("opa hi", 64'(opa[63:32]), 64'(rd));
    wb_read(REG_OPB_LO, rd);
    check("opb lo", 64'(opb[31:0]), 64'(rd));
    wb_read(REG_OPB_HI, rd);
    check("opb hi", 64'(opb[63:32]), 64'(rd));
    wb_read(REG_CTRL, rd);
    check("ctrl", 64'h317, 64'(rd));
    run_op("undefined op", alu_op_e'(5'd27), EW32, 64'hFFFF_FFFF_FFFF_FFFF,
           64'hFFFF_FFFF_FFFF_FFFF);

    for (int v = 0; v < 4; v++) begin
      // Logic and wrapping arithmetic
      for (int o = OP_AND; o <= OP_RSUB; o++) begin
        for (int i = 0; i < RAND_ITERS; i++) begin
          run_op(op_tag(alu_op_e'(o[4:0]), vew_e'(v[1:0])), alu_op_e'(o[4:0]),
                 vew_e'(v[1:0]), rand64(), rand64());
        end
      end
      // Saturation with directed then random operands
      for (int o = OP_SADDU; o <= OP_SSUB; o++) begin
        for (int p = 0; p < 6; p++) begin
          run_op(op_tag(alu_op_e'(o[4:0]), vew_e'(v[1:0])), alu_op_e'(o[4:0]),
                 vew_e'(v[1:0]), sat_a[p], sat_b[p]);
        end
        for (int i = 0; i < RAND_ITERS; i++) begin
          run_op(op_tag(alu_op_e'(o[4:0]), vew_e'(v[1:0])), alu_op_e'(o[4:0]),
                 vew_e'(v[1:0]), rand64(), rand64());
        end
      end
      // Shifts, min and max
      for (int o = OP_SLL; o <= OP_MAX; o++) begin
        for (int i = 0; i < RAND_ITERS; i++) begin
          run_op(op_tag(alu_op_e'(o[4:0]), vew_e'(v[1:0])), alu_op_e'(o[4:0]),
                 vew_e'(v[1:0]), rand64(), rand64());
        end
      end
      // Compares with every lane equal on the first pass, random lanes after
      for (int o = OP_MSEQ; o <= OP_MSGTU; o++) begin
        for (int i = 0; i < RAND_ITERS; i++) begin
          opa = rand64();
          opb = mix_equal_lanes(vew_e'(v[1:0]), opa, rand64(),
                                (i == 0) ? 8'hFF : 8'($urandom));
          run_op(op_tag(alu_op_e'(o[4:0]), vew_e'(v[1:0])), alu_op_e'(o[4:0]),
                 vew_e'(v[1:0]), opa, opb);
        end
      end
    end

    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: wb_alu_regs.sv
module wb_alu_regs import simd_alu_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     wb_cyc_i,
  input  logic     wb_stb_i,
  input  logic     wb_we_i,
  input  wb_addr_t wb_adr_i,
  input  wb_data_t wb_dat_i,
  input  elen_t    result_i,
  input  strb_t    vxsat_i,
  input  logic     done_i,
  output wb_data_t wb_dat_o,
  output logic     wb_ack_o,
  alu_req_if.regs_mp req
);

  logic     ack_q;
  logic     acc_en;
  logic     wr_en;
  logic     ctrl_wr;
  reg_idx_t idx;

  elen_t    opa_q;
  elen_t    opb_q;
  alu_op_e  op_q;
  vew_e     vew_q;
  logic     start_q;
  logic     done_q;
  wb_data_t rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Bus handshake and decode
  ////////////////////////////////////////////////////////////////////////////

  // New access only while no ack is pending
  assign acc_en  = wb_cyc_i & wb_stb_i & ~ack_q;
  assign wr_en   = acc_en & wb_we_i;
  assign idx     = wb_adr_i[4:2];
  assign ctrl_wr = wr_en && (idx == REG_CTRL);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q   <= 1'b0;
      start_q <= 1'b0;
      done_q  <= 1'b0;
      opa_q   <= '0;
      opb_q   <= '0;
      op_q    <= OP_AND;
      vew_q   <= EW8;
    end else begin
      ack_q   <= acc_en;
      start_q <= ctrl_wr;

      if (wr_en) begin
        case (idx)
          REG_OPA_LO: opa_q[31:0]  <= wb_dat_i;
          REG_OPA_HI: opa_q[63:32] <= wb_dat_i;
          REG_OPB_LO: opb_q[31:0]  <= wb_dat_i;
          REG_OPB_HI: opb_q[63:32] <= wb_dat_i;
          REG_CTRL: begin
            op_q  <= alu_op_e'(wb_dat_i[CTRL_OP_MSB:CTRL_OP_LSB]);
            vew_q <= vew_e'(wb_dat_i[CTRL_VEW_MSB:CTRL_VEW_LSB]);
          end
          default: ;
        endcase
      end

      // Sticky done, cleared by a new request
      if (ctrl_wr) begin
        done_q <= 1'b0;
      end else if (done_i) begin
        done_q <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read-back
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata = '0;
    case (idx)
      REG_OPA_LO: rdata = opa_q[31:0];
      REG_OPA_HI: rdata = opa_q[63:32];
      REG_OPB_LO: rdata = opb_q[31:0];
      REG_OPB_HI: rdata = opb_q[63:32];
      REG_CTRL: begin
        rdata[CTRL_OP_MSB:CTRL_OP_LSB]   = op_q;
        rdata[CTRL_VEW_MSB:CTRL_VEW_LSB] = vew_q;
      end
      REG_STATUS: begin
        rdata[STAT_DONE_BIT]                 = done_q;
        rdata[STAT_VXSAT_MSB:STAT_VXSAT_LSB] = vxsat_i;
      end
      REG_RES_LO: rdata = result_i[31:0];
      REG_RES_HI: rdata = result_i[63:32];
      default:    rdata = '0;
    endcase
  end

  assign wb_dat_o  = rdata;
  assign wb_ack_o  = ack_q;

  assign req.opa   = opa_q;
  assign req.opb   = opb_q;
  assign req.op    = op_q;
  assign req.vew   = vew_q;
  assign req.start = start_q;

endmodule
